// ==== files.f ====
+incdir+source
source/cache_pkg.sv
source/cache_control.sv
source/cache_store.sv
source/line_buffer.sv
source/direct_cache.sv
dv/cache_props.sv
dv/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the direct-mapped cache testbench

VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = cache_tb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_TEXT = all tests passed

SOURCES = $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/cache_cases.txt ====
// columns: byte address, request tag, kind, respack stall cycles per beat
// kind 0 expects a miss, 1 a hit, 2 resets the DUT, f ends the list
0000000000000000 0001 0 0
0000000000000040 0002 0 0
0000000000000098 0003 0 1
0000000000000020 0004 1 0
000000000000007f 0005 1 2
0000000000000800 0006 0 0
0000000000000808 0007 1 3
0000000000000010 0008 0 0
123456789abc07c0 0009 0 1
123456789abc07f8 000a 1 4
0000000000000088 000b 1 0
0000000000000000 0000 2 0
0000000000000088 000c 0 0
123456789abc07c0 000d 0 2
123456789abc07c0 000e 1 5
0000000000000fc0 1fff 0 0
123456789abc07e0 0010 0 1
0000000000000000 0000 f 0

// ==== dv/cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_tb import cache_pkg::*; ();

	localparam beat_t DATA_KEY     = 64'h5a5a_0f0f_a5a5_f0f0;   // memory content rule
	localparam int    MAX_CASES    = 32;
	localparam int    RESET_CYCLES = 16;

	logic     clk;
	logic     reset;

	logic     p_bus_reqcyc;
	logic     p_bus_reqack;
	addr_t    p_bus_req;
	bus_tag_t p_bus_reqtag;
	logic     p_bus_respcyc;
	logic     p_bus_respack;
	beat_t    p_bus_resp;
	bus_tag_t p_bus_resptag;

	logic     m_bus_reqcyc;
	logic     m_bus_reqack;
	addr_t    m_bus_req;
	bus_tag_t m_bus_reqtag;
	logic     m_bus_respcyc;
	logic     m_bus_respack;
	beat_t    m_bus_resp;

	logic [63:0] case_words [4*MAX_CASES];   // four words per case line
	int          num_cases;
	int          cycle_count  = 0;
	int          cycle_limit  = 0;           // 0 until the cases are read
	int          mem_requests = 0;           // memory requests seen in the current case
	integer      seed         = 32'he8a5_6c11;
	addr_t       cur_addr;                   // request in flight, for the memory checks
	bus_tag_t    cur_tag;

	direct_cache UUT (.*);

	bind direct_cache cache_props u_props (
		.clk(clk), .reset(reset),
		.p_bus_reqack(p_bus_reqack), .p_bus_respcyc(p_bus_respcyc),
		.p_bus_respack(p_bus_respack), .p_bus_resp(p_bus_resp),
		.p_bus_resptag(p_bus_resptag),
		.m_bus_reqcyc(m_bus_reqcyc), .m_bus_reqack(m_bus_reqack),
		.m_bus_respcyc(m_bus_respcyc), .m_bus_respack(m_bus_respack)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// run limit, armed once the case list is known
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("tests failed");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("error: %s is %h, expected %h", name, actual, expected);
			$display("tests failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// beat content is its byte address xor the key
	function automatic beat_t rule_beat(input addr_t line_addr, input int index);
		return beat_t'(line_addr + addr_t'(index * 8)) ^ DATA_KEY;
	endfunction

	function automatic addr_t line_base(input addr_t addr);
		return addr & ~addr_t'(`CACHE_BEATS * 8 - 1);   // clear the 64-byte offset
	endfunction

	function automatic int random_below(input int span);
		return int'($unsigned($random(seed)) % span);
	endfunction

	task automatic wait_cycle();
		@(posedge clk);
		#1;   // inputs move just after the edge
	endtask

	task automatic apply_reset(input int cycles);
		reset = 1'b1;
		repeat (cycles) wait_cycle();
		reset = 1'b0;
	endtask

	task automatic read_cases();
		int i;
		$readmemh("dv/cache_cases.txt", case_words);
		i = 0;
		while (i < MAX_CASES && case_words[4*i+2] != 64'hf)
			i++;
		num_cases = i;
		if (num_cases == 0) begin
			$display("the cases file holds no test case");
			$display("tests failed");
			$fatal(1, "empty case list");
		end
	endtask

	// one processor request, all 8 beats checked against the memory rule
	task automatic run_case(input addr_t addr, input bus_tag_t tag, input logic expect_hit,
		input int stall);
		addr_t line_addr;
		line_addr    = line_base(addr);
		cur_addr     = addr;
		cur_tag      = tag;
		mem_requests = 0;
		p_bus_req    = addr;
		p_bus_reqtag = tag;
		p_bus_reqcyc = 1'b1;
		wait_cycle();
		while (!p_bus_reqack)
			wait_cycle();
		p_bus_reqcyc = 1'b0;   // ack seen, request is taken
		for (int b = 0; b < `CACHE_BEATS; b++) begin
			while (!p_bus_respcyc)
				wait_cycle();
			check_value("p_bus_resp", p_bus_resp, rule_beat(line_addr, b));
			check_value("p_bus_resptag", 64'(p_bus_resptag), 64'(tag));
			repeat (stall) wait_cycle();   // hold off the ack
			check_value("p_bus_resp", p_bus_resp, rule_beat(line_addr, b));
			p_bus_respack = 1'b1;
			wait_cycle();
			p_bus_respack = 1'b0;
		end
		check_value("m_bus_reqcyc count", 64'(mem_requests), expect_hit ? 64'd0 : 64'd1);
	endtask

	// memory model with random ack delay and random gaps between beats
	initial begin : memory_model
		int    wait_cycles;
		addr_t line_addr;
		m_bus_reqack  = 1'b0;
		m_bus_respcyc = 1'b0;
		m_bus_resp    = '0;
		forever begin
			wait_cycle();
			if (m_bus_reqcyc) begin
				mem_requests = mem_requests + 1;
				line_addr    = line_base(cur_addr);
				check_value("m_bus_req", m_bus_req, line_addr);
				check_value("m_bus_reqtag", 64'(m_bus_reqtag), 64'(cur_tag));
				wait_cycles = random_below(4);
				repeat (wait_cycles) wait_cycle();
				m_bus_reqack = 1'b1;
				wait_cycle();
				m_bus_reqack = 1'b0;
				for (int b = 0; b < `CACHE_BEATS; b++) begin
					wait_cycles = random_below(4);
					repeat (wait_cycles) wait_cycle();
					m_bus_respcyc = 1'b1;
					m_bus_resp    = rule_beat(line_addr, b);
					@(negedge clk);   // respack answers the beat within its own cycle
					check_value("m_bus_respack", 64'(m_bus_respack), 64'd1);
					wait_cycle();   // cache takes it on this edge
					m_bus_respcyc = 1'b0;
				end
			end
		end
	end

	initial begin : main_sequence
		logic [63:0] kind;
		int          limit;
		reset         = 1'b1;
		p_bus_reqcyc  = 1'b0;
		p_bus_req     = '0;
		p_bus_reqtag  = '0;
		p_bus_respack = 1'b0;
		read_cases();
		limit = RESET_CYCLES;
		for (int i = 0; i < num_cases; i++)
			limit = limit + 200 + 8 * int'(case_words[4*i+3]);   // stall hits every beat
		cycle_limit = limit;
		apply_reset(RESET_CYCLES);
		for (int i = 0; i < num_cases; i++) begin
			kind = case_words[4*i+2];
			if (kind == 64'h2)
				apply_reset(4);   // mid-run reset, all lines invalid again
			else
				run_case(case_words[4*i], bus_tag_t'(case_words[4*i+1]), kind[0],
					int'(case_words[4*i+3]));
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== dv/cache_props.sv ====
`timescale 1ns/100ps

module cache_props import cache_pkg::*; (
	input logic     clk,
	input logic     reset,
	input logic     p_bus_reqack,
	input logic     p_bus_respcyc,
	input logic     p_bus_respack,
	input beat_t    p_bus_resp,
	input bus_tag_t p_bus_resptag,
	input logic     m_bus_reqcyc,
	input logic     m_bus_reqack,
	input logic     m_bus_respcyc,
	input logic     m_bus_respack
);

	// request ack is a single pulse per accepted request
	reqack_pulse: assert property (@(posedge clk) disable iff (reset)
		p_bus_reqack |=> !p_bus_reqack)
		else $error("p_bus_reqack stayed high for more than one cycle");

	// memory request must wait for its ack
	mem_req_hold: assert property (@(posedge clk) disable iff (reset)
		m_bus_reqcyc && !m_bus_reqack |=> m_bus_reqcyc)
		else $error("m_bus_reqcyc dropped before m_bus_reqack");

	// beat and tag frozen while the processor holds off
	resp_stable: assert property (@(posedge clk) disable iff (reset)
		p_bus_respcyc && !p_bus_respack |=>
			p_bus_respcyc && $stable(p_bus_resp) && $stable(p_bus_resptag))
		else $error("processor response changed while respack was low");

	// memory ack only answers a presented beat
	respack_needs_beat: assert property (@(posedge clk) disable iff (reset)
		m_bus_respack |-> m_bus_respcyc)
		else $error("m_bus_respack high without m_bus_respcyc");

endmodule

// ==== source/direct_cache.sv ====
`timescale 1ns/100ps
`include "cache_config.svh"

module direct_cache import cache_pkg::*; (
	input  logic     clk,
	input  logic     reset,

	// processor side
	input  logic     p_bus_reqcyc,
	output logic     p_bus_reqack,
	input  addr_t    p_bus_req,
	input  bus_tag_t p_bus_reqtag,
	output logic     p_bus_respcyc,
	input  logic     p_bus_respack,
	output beat_t    p_bus_resp,
	output bus_tag_t p_bus_resptag,

	// memory side
	output logic     m_bus_reqcyc,
	input  logic     m_bus_reqack,
	output addr_t    m_bus_req,
	output bus_tag_t m_bus_reqtag,
	input  logic     m_bus_respcyc,
	output logic     m_bus_respack,
	input  beat_t    m_bus_resp
);

	set_index_t set_index;
	set_tag_t   set_tag;
	logic       hit;
	logic       fill_write;
	logic       load_stored;
	logic       fill_beat_valid;
	beat_ptr_t  beat_ptr;
	line_t      stored_line;   // store to buffer
	line_t      fill_line;     // buffer to store

	cache_control u_control (
		.clk, .reset,
		.p_bus_reqcyc, .p_bus_req, .p_bus_reqtag, .p_bus_reqack,
		.p_bus_respcyc, .p_bus_respack, .p_bus_resptag,
		.m_bus_reqcyc, .m_bus_reqack, .m_bus_req, .m_bus_reqtag,
		.m_bus_respcyc, .m_bus_respack,
		.hit, .set_index, .set_tag, .fill_write,
		.load_stored, .fill_beat_valid, .beat_ptr
	);

	cache_store u_store (
		.clk, .reset,
		.set_index, .set_tag, .fill_write,
		.fill_line,
		.hit, .stored_line
	);

	// memory beats go straight into the buffer, its beat output drives the processor bus
	line_buffer u_buffer (
		.clk,
		.stored_line, .load_stored,
		.fill_beat_valid, .fill_beat(m_bus_resp),
		.beat_ptr,
		.line(fill_line), .beat(p_bus_resp)
	);

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/100ps
`include "cache_config.svh"

module line_buffer import cache_pkg::*; (
	input  logic      clk,
	input  line_t     stored_line,       // line read from cache_store
	input  logic      load_stored,       // take the whole line
	input  logic      fill_beat_valid,   // take one memory beat
	input  beat_t     fill_beat,
	input  beat_ptr_t beat_ptr,          // slot for fill and for output
	output line_t     line,
	output beat_t     beat
);

	beat_t slots [`CACHE_BEATS];   // slot 0 holds the lowest addressed beat

	// load whole line or one slot; load wins, they never overlap anyway
	always_ff @(posedge clk) begin
		if (load_stored) begin
			for (int i = 0; i < `CACHE_BEATS; i++)
				slots[i] <= stored_line[i*`CACHE_BEAT_WIDTH +: `CACHE_BEAT_WIDTH];
		end else if (fill_beat_valid) begin
			slots[beat_ptr] <= fill_beat;
		end
	end

	// pack slots back into a line for the store fill
	always_comb begin
		for (int i = 0; i < `CACHE_BEATS; i++)
			line[i*`CACHE_BEAT_WIDTH +: `CACHE_BEAT_WIDTH] = slots[i];
	end

	assign beat = slots[beat_ptr];   // held while the pointer holds

endmodule

// ==== source/cache_store.sv ====
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_store import cache_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  set_index_t set_index,    // from captured address
	input  set_tag_t   set_tag,
	input  logic       fill_write,   // one cycle, in update
	input  line_t      fill_line,    // assembled line from line_buffer
	output logic       hit,
	output line_t      stored_line
);

	logic [`CACHE_SETS-1:0] valid;   // one per set
	set_tag_t tags  [`CACHE_SETS];   // address tag per set
	line_t    lines [`CACHE_SETS];   // line data per set

	logic tag_match;

	// valid bits are the only control state in here
	always_ff @(posedge clk) begin
		if (reset)
			valid <= '0;
		else if (fill_write)
			valid[set_index] <= 1'b1;
	end

	// tag and data arrays
	always_ff @(posedge clk) begin
		if (fill_write) begin
			tags[set_index]  <= set_tag;
			lines[set_index] <= fill_line;
		end
	end

	// lookup reads the indexed set straight out of the arrays
	assign tag_match = (tags[set_index] == set_tag);
	assign hit       = valid[set_index] && tag_match;

	// a stale line can show up here on a miss, nobody loads it then
	assign stored_line = lines[set_index];

endmodule

// ==== source/cache_control.sv ====
`timescale 1ns/100ps
`include "cache_config.svh"

module cache_control import cache_pkg::*; (
	input  logic         clk,
	input  logic         reset,

	// processor side
	input  logic         p_bus_reqcyc,
	input  addr_t        p_bus_req,
	input  bus_tag_t     p_bus_reqtag,
	output logic         p_bus_reqack,
	output logic         p_bus_respcyc,
	input  logic         p_bus_respack,
	output bus_tag_t     p_bus_resptag,

	// memory side
	output logic         m_bus_reqcyc,
	input  logic         m_bus_reqack,
	output addr_t        m_bus_req,
	output bus_tag_t     m_bus_reqtag,
	input  logic         m_bus_respcyc,
	output logic         m_bus_respack,

	// to and from the datapath
	input  logic         hit,
	output set_index_t   set_index,
	output set_tag_t     set_tag,
	output logic         fill_write,
	output logic         load_stored,
	output logic         fill_beat_valid,
	output beat_ptr_t    beat_ptr
);

	cache_state_t state;
	cache_state_t next_state;

	addr_t    req_addr;    // address captured on accept
	bus_tag_t req_tag;     // tag captured on accept

	logic accept;          // request taken this cycle
	logic last_beat;       // counter sits on beat 7
	logic beat_step;       // a beat moved on either bus

	assign accept    = (state == idle) && p_bus_reqcyc;
	assign last_beat = (beat_ptr == beat_ptr_t'(`CACHE_BEATS - 1));

	// memory beats are taken the same cycle they show up
	assign m_bus_respack   = (state == mem_receive) && m_bus_respcyc;
	assign fill_beat_valid = m_bus_respack;   // line buffer takes the beat on this edge

	assign beat_step = m_bus_respack || (p_bus_respcyc && p_bus_respack);

	// state register and beat counter
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= idle;
			beat_ptr <= '0;
		end else begin
			state <= next_state;
			if (state == ack_proc)
				beat_ptr <= '0;               // fresh count per request
			else if (beat_step)
				beat_ptr <= beat_ptr + 1'b1;  // wraps to 0 after beat 7
		end
	end

	// request capture, payload only
	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= p_bus_req;
			req_tag  <= p_bus_reqtag;
		end
	end

	// next state
	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (p_bus_reqcyc)
					next_state = ack_proc;
			end
			ack_proc:
				next_state = lookup;
			lookup: begin
				if (hit)
					next_state = respond;   // line already here
				else
					next_state = mem_req;
			end
			mem_req: begin
				if (m_bus_reqack)
					next_state = mem_receive;
			end
			mem_receive: begin
				// leave after the eighth accepted beat
				if (m_bus_respcyc && last_beat)
					next_state = update;
			end
			update:
				next_state = respond;
			respond:
				next_state = resp_wait;
			resp_wait: begin
				if (p_bus_respack && last_beat)
					next_state = idle;
			end
			default:
				next_state = idle;
		endcase
	end

	// processor handshake
	assign p_bus_reqack  = (state == ack_proc);    // single cycle by construction
	assign p_bus_respcyc = (state == resp_wait);
	assign p_bus_resptag = req_tag;

	// memory request is always for the whole line
	assign m_bus_reqcyc = (state == mem_req);
	assign m_bus_req    = {req_addr[`CACHE_ADDR_WIDTH-1:`CACHE_OFFSET_BITS],
		{`CACHE_OFFSET_BITS{1'b0}}};
	assign m_bus_reqtag = req_tag;

	// split of the captured address
	assign set_index = req_addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
	assign set_tag   = req_addr[`CACHE_ADDR_WIDTH-1 -: `CACHE_SET_TAG_WIDTH];

	// datapath strobes
	assign fill_write  = (state == update);
	// store is read again after a fill, so both paths reload here
	assign load_stored = (state == respond);

endmodule

// ==== source/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

	typedef logic [`CACHE_ADDR_WIDTH-1:0]    addr_t;      // byte address
	typedef logic [`CACHE_BEAT_WIDTH-1:0]    beat_t;      // one bus beat
	typedef logic [`CACHE_LINE_WIDTH-1:0]    line_t;      // whole cache line
	typedef logic [`CACHE_BUS_TAG_WIDTH-1:0] bus_tag_t;   // request tag
	typedef logic [`CACHE_INDEX_BITS-1:0]    set_index_t;
	typedef logic [`CACHE_SET_TAG_WIDTH-1:0] set_tag_t;   // upper address bits kept per set

	// counts beats 0..7 on both buses
	typedef logic [$clog2(`CACHE_BEATS)-1:0] beat_ptr_t;

	// controller states, in walk order
	typedef enum logic [2:0] {
		idle,          // waiting for p_bus_reqcyc
		ack_proc,      // reqack pulse to processor
		lookup,        // tag compare on captured address
		mem_req,       // m_bus_reqcyc up until acked
		mem_receive,   // collect 8 beats from memory
		update,        // write the filled line into the store
		respond,       // load line buffer from the store
		resp_wait      // present beats until each is acked
	} cache_state_t;

endpackage

// ==== source/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// bus widths, shared by processor and memory side
`define CACHE_ADDR_WIDTH     64   // byte address
`define CACHE_BEAT_WIDTH     64   // one data beat
`define CACHE_BUS_TAG_WIDTH  13   // request tag

// geometry of the direct-mapped array
`define CACHE_SETS           32
`define CACHE_INDEX_BITS     5    // log2 of set count
`define CACHE_OFFSET_BITS    6    // 64-byte line
`define CACHE_BEATS          8    // beats per line

// derived sizes
`define CACHE_LINE_WIDTH     (`CACHE_BEAT_WIDTH * `CACHE_BEATS)
`define CACHE_SET_TAG_WIDTH  (`CACHE_ADDR_WIDTH - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

`endif
